//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_issue_stage -f sim.f -Mdir obj_dir
	./obj_dir/Vtb_issue_stage | tee sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- hdl/cdb_arbiter.sv
module cdb_arbiter (
    input  logic                                                         clock,
    input  logic                                                         reset,
    input  logic                                                         mult_cdb_req,
    issue_grant_if.arbiter                                               grant,
    output logic                                                         mult_cdb_gnt,
    output logic [issue_pkg::cdb_width-1:0][issue_pkg::num_fu_total-1:0] complete_gnt
);

    // bit 0 mult, bit 1 alu lane 0, bit 2 alu lane 1
    logic [issue_pkg::num_fu_total-1:0] cdb_req;
    // per-slot owner, one-hot or zero
    logic [issue_pkg::cdb_width-1:0][issue_pkg::num_fu_total-1:0] slot_gnt;
    // units that got any slot this cycle
    logic [issue_pkg::num_fu_total-1:0] fu_won;

    // the mult result is already in flight, so it goes ahead of new alu work
    assign cdb_req = {grant.alu_cand, mult_cdb_req};

    priority_select #(
        .width  (issue_pkg::num_fu_total),
        .grants (issue_pkg::cdb_width)
    ) i_slot_select (
        .req (cdb_req),
        .gnt (slot_gnt),
        .any ()
    );

    always_comb begin
        fu_won = '0;
        for (int s = 0; s < issue_pkg::cdb_width; s++) begin
            fu_won = fu_won | slot_gnt[s];
        end
    end

    // an alu lane without a slot waits, its entry stays ready
    assign grant.alu_issue = fu_won[issue_pkg::num_fu_total-1:1] & grant.alu_cand;
    assign mult_cdb_gnt = fu_won[0];

    // slot ownership seen by complete one cycle later
    always_ff @(posedge clock) begin
        if (reset) begin
            complete_gnt <= '0;
        end else begin
            complete_gnt <= slot_gnt;
        end
    end

endmodule

//--- hdl/entry_select.sv
module entry_select (
    input  logic [issue_pkg::rs_size-1:0]                        rs_valid,
    input  logic [issue_pkg::rs_size-1:0]                        rs_src1_ready,
    input  logic [issue_pkg::rs_size-1:0]                        rs_src2_ready,
    input  issue_pkg::fu_class_t [issue_pkg::rs_size-1:0]        rs_fu_class,
    input  logic                                                 mult_free,
    issue_grant_if.select                                        grant
);

    // entries with both operands available
    logic [issue_pkg::rs_size-1:0] ready;
    logic [issue_pkg::rs_size-1:0] alu_req;
    logic [issue_pkg::rs_size-1:0] mult_req;

    logic [issue_pkg::num_alu-1:0][issue_pkg::rs_size-1:0] alu_gnt;
    logic [issue_pkg::num_alu-1:0] alu_any;
    logic [0:0][issue_pkg::rs_size-1:0] mult_gnt;
    logic [0:0] mult_any;

    // one-hot to binary, or-reduce of set positions
    function automatic issue_pkg::rs_index_t onehot_to_index(
        input logic [issue_pkg::rs_size-1:0] onehot
    );
        issue_pkg::rs_index_t index;
        index = '0;
        for (int i = 0; i < issue_pkg::rs_size; i++) begin
            if (onehot[i]) begin
                index = index | issue_pkg::rs_index_t'(i);
            end
        end
        return index;
    endfunction

    always_comb begin
        ready = rs_valid & rs_src1_ready & rs_src2_ready;
        for (int i = 0; i < issue_pkg::rs_size; i++) begin
            alu_req[i] = ready[i] && (rs_fu_class[i] == issue_pkg::fu_alu);
            mult_req[i] = ready[i] && (rs_fu_class[i] == issue_pkg::fu_mult);
        end
    end

    // lane k takes the k-th lowest ready alu entry
    priority_select #(
        .width  (issue_pkg::rs_size),
        .grants (issue_pkg::num_alu)
    ) i_alu_select (
        .req (alu_req),
        .gnt (alu_gnt),
        .any (alu_any)
    );

    // single multiplier, lowest ready mult entry
    priority_select #(
        .width  (issue_pkg::rs_size),
        .grants (1)
    ) i_mult_select (
        .req (mult_req),
        .gnt (mult_gnt),
        .any (mult_any)
    );

    // lanes only become candidates here, the cdb decides
    assign grant.alu_cand = alu_any;

    for (genvar k = 0; k < issue_pkg::num_alu; k++) begin : g_alu_index
        assign grant.alu_index[k] = onehot_to_index(alu_gnt[k]);
    end

    // busy multiplier keeps its entry in the rs
    assign grant.mult_issue = mult_any[0] & mult_free;
    assign grant.mult_index = onehot_to_index(mult_gnt[0]);

endmodule

//--- hdl/issue_grant_if.sv
interface issue_grant_if;

    // per alu lane: a ready entry was found for this lane
    logic [issue_pkg::num_alu-1:0] alu_cand;
    // rs slot picked for each alu lane
    issue_pkg::rs_index_t [issue_pkg::num_alu-1:0] alu_index;
    // lane really issues, i.e. it also won a cdb slot
    logic [issue_pkg::num_alu-1:0] alu_issue;

    // multiply entry, already qualified by mult_free
    logic mult_issue;
    issue_pkg::rs_index_t mult_index;

    modport select (output alu_cand, alu_index, mult_issue, mult_index);

    modport arbiter (input alu_cand, output alu_issue);

    modport gather (input alu_issue, alu_index, mult_issue, mult_index);

endinterface

//--- hdl/issue_pkg.sv
package issue_pkg;

    // reservation station geometry
    localparam int rs_size = 8;
    localparam int rs_index_bits = 3;

    // execution resources
    localparam int num_alu = 2;
    localparam int cdb_width = 2;

    // two source reads per alu lane, then two for the multiplier
    localparam int num_read_ports = 6;

    // completion grant bit order: mult, alu lane 0, alu lane 1
    localparam int num_fu_total = 3;

    localparam int phys_reg_count = 32;

    typedef logic [$clog2(phys_reg_count)-1:0] phys_reg_idx_t;
    typedef logic [rs_index_bits-1:0] rs_index_t;
    typedef logic [31:0] data_t;

    // which unit class an rs entry is waiting for
    typedef enum logic {
        fu_alu  = 1'b0,
        fu_mult = 1'b1
    } fu_class_t;

    // alu view of the function code
    typedef enum logic [3:0] {
        alu_add = 4'h0,
        alu_sub = 4'h1,
        alu_and = 4'h2,
        alu_or  = 4'h3,
        alu_xor = 4'h4,
        alu_sll = 4'h5,
        alu_srl = 4'h6,
        alu_slt = 4'h7
    } alu_op_t;

    // multiplier result selection
    typedef enum logic [1:0] {
        mult_low     = 2'd0,
        mult_high    = 2'd1,
        mult_high_su = 2'd2,
        mult_high_u  = 2'd3
    } mult_kind_t;

    // mult view, kind sits in the low bits
    typedef struct packed {
        logic [1:0] reserved;
        mult_kind_t mult_kind;
    } mult_func_t;

    // same 4-bit word, read per unit class
    typedef union packed {
        alu_op_t    alu_op;
        mult_func_t mult;
    } func_code_t;

endpackage

//--- hdl/issue_stage.sv
module issue_stage (
    input  logic                                                         clock,
    input  logic                                                         reset,

    // rs contents
    input  logic [issue_pkg::rs_size-1:0]                                rs_valid,
    input  logic [issue_pkg::rs_size-1:0]                                rs_src1_ready,
    input  logic [issue_pkg::rs_size-1:0]                                rs_src2_ready,
    input  issue_pkg::fu_class_t [issue_pkg::rs_size-1:0]                rs_fu_class,
    input  issue_pkg::phys_reg_idx_t [issue_pkg::rs_size-1:0]            rs_src1,
    input  issue_pkg::phys_reg_idx_t [issue_pkg::rs_size-1:0]            rs_src2,
    input  issue_pkg::phys_reg_idx_t [issue_pkg::rs_size-1:0]            rs_dest,
    input  issue_pkg::func_code_t [issue_pkg::rs_size-1:0]               rs_func,
    output logic [issue_pkg::rs_size-1:0]                                rs_issuing,

    // committed-value bits per physical register
    input  logic [issue_pkg::phys_reg_count-1:0]                         complete_list,

    // cdb broadcast of this cycle
    input  logic [issue_pkg::cdb_width-1:0]                              cdb_valid,
    input  issue_pkg::phys_reg_idx_t [issue_pkg::cdb_width-1:0]          cdb_tag,
    input  issue_pkg::data_t [issue_pkg::cdb_width-1:0]                  cdb_result,

    // register file read ports
    output issue_pkg::phys_reg_idx_t [issue_pkg::num_read_ports-1:0]     rf_read_idx,
    input  issue_pkg::data_t [issue_pkg::num_read_ports-1:0]             rf_read_data,

    // multiplier status and cdb handshake levels
    input  logic                                                         mult_free,
    input  logic                                                         mult_cdb_req,
    output logic                                                         mult_cdb_gnt,
    output logic [issue_pkg::cdb_width-1:0][issue_pkg::num_fu_total-1:0] complete_gnt,

    // alu packets
    output logic [issue_pkg::num_alu-1:0]                                alu_valid,
    output issue_pkg::phys_reg_idx_t [issue_pkg::num_alu-1:0]            alu_dest,
    output issue_pkg::alu_op_t [issue_pkg::num_alu-1:0]                  alu_op,
    output issue_pkg::data_t [issue_pkg::num_alu-1:0]                    alu_opa,
    output issue_pkg::data_t [issue_pkg::num_alu-1:0]                    alu_opb,

    // mult packet
    output logic                                                         mult_valid,
    output issue_pkg::phys_reg_idx_t                                     mult_dest,
    output issue_pkg::mult_kind_t                                        mult_kind,
    output issue_pkg::data_t                                             mult_opa,
    output issue_pkg::data_t                                             mult_opb
);

    // candidates, chosen entries and final issue bits
    issue_grant_if grant_bus ();

    entry_select i_entry_select (
        .rs_valid      (rs_valid),
        .rs_src1_ready (rs_src1_ready),
        .rs_src2_ready (rs_src2_ready),
        .rs_fu_class   (rs_fu_class),
        .mult_free     (mult_free),
        .grant         (grant_bus.select)
    );

    cdb_arbiter i_cdb_arbiter (
        .clock        (clock),
        .reset        (reset),
        .mult_cdb_req (mult_cdb_req),
        .grant        (grant_bus.arbiter),
        .mult_cdb_gnt (mult_cdb_gnt),
        .complete_gnt (complete_gnt)
    );

    operand_gather i_operand_gather (
        .grant         (grant_bus.gather),
        .rs_src1       (rs_src1),
        .rs_src2       (rs_src2),
        .rs_dest       (rs_dest),
        .rs_func       (rs_func),
        .complete_list (complete_list),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .cdb_result    (cdb_result),
        .rf_read_idx   (rf_read_idx),
        .rf_read_data  (rf_read_data),
        .alu_valid     (alu_valid),
        .alu_dest      (alu_dest),
        .alu_op        (alu_op),
        .alu_opa       (alu_opa),
        .alu_opb       (alu_opb),
        .mult_valid    (mult_valid),
        .mult_dest     (mult_dest),
        .mult_kind     (mult_kind),
        .mult_opa      (mult_opa),
        .mult_opb      (mult_opb),
        .rs_issuing    (rs_issuing)
    );

endmodule

//--- hdl/operand_gather.sv
module operand_gather (
    issue_grant_if.gather                                             grant,
    input  issue_pkg::phys_reg_idx_t [issue_pkg::rs_size-1:0]         rs_src1,
    input  issue_pkg::phys_reg_idx_t [issue_pkg::rs_size-1:0]         rs_src2,
    input  issue_pkg::phys_reg_idx_t [issue_pkg::rs_size-1:0]         rs_dest,
    input  issue_pkg::func_code_t [issue_pkg::rs_size-1:0]            rs_func,
    input  logic [issue_pkg::phys_reg_count-1:0]                      complete_list,
    input  logic [issue_pkg::cdb_width-1:0]                           cdb_valid,
    input  issue_pkg::phys_reg_idx_t [issue_pkg::cdb_width-1:0]       cdb_tag,
    input  issue_pkg::data_t [issue_pkg::cdb_width-1:0]               cdb_result,
    output issue_pkg::phys_reg_idx_t [issue_pkg::num_read_ports-1:0]  rf_read_idx,
    input  issue_pkg::data_t [issue_pkg::num_read_ports-1:0]          rf_read_data,
    output logic [issue_pkg::num_alu-1:0]                             alu_valid,
    output issue_pkg::phys_reg_idx_t [issue_pkg::num_alu-1:0]         alu_dest,
    output issue_pkg::alu_op_t [issue_pkg::num_alu-1:0]               alu_op,
    output issue_pkg::data_t [issue_pkg::num_alu-1:0]                 alu_opa,
    output issue_pkg::data_t [issue_pkg::num_alu-1:0]                 alu_opb,
    output logic                                                      mult_valid,
    output issue_pkg::phys_reg_idx_t                                  mult_dest,
    output issue_pkg::mult_kind_t                                     mult_kind,
    output issue_pkg::data_t                                          mult_opa,
    output issue_pkg::data_t                                          mult_opb,
    output logic [issue_pkg::rs_size-1:0]                             rs_issuing
);

    // alu lanes first, multiplier last; lane l owns read ports 2l and 2l+1
    logic [issue_pkg::num_read_ports/2-1:0] lane_issue;
    issue_pkg::rs_index_t [issue_pkg::num_read_ports/2-1:0] lane_index;
    issue_pkg::data_t [issue_pkg::num_read_ports-1:0] operand;

    // regfile if the value is committed, else cam the cdb; last matching slot wins
    function automatic issue_pkg::data_t forward_operand(
        input issue_pkg::phys_reg_idx_t                            tag,
        input issue_pkg::data_t                                    rf_data,
        input logic [issue_pkg::phys_reg_count-1:0]                complete,
        input logic [issue_pkg::cdb_width-1:0]                     valid,
        input issue_pkg::phys_reg_idx_t [issue_pkg::cdb_width-1:0] tags,
        input issue_pkg::data_t [issue_pkg::cdb_width-1:0]         results
    );
        issue_pkg::data_t value;
        value = '0;
        if (complete[tag]) begin
            value = rf_data;
        end else begin
            for (int j = 0; j < issue_pkg::cdb_width; j++) begin
                if (valid[j] && (tags[j] == tag)) begin
                    value = results[j];
                end
            end
        end
        return value;
    endfunction

    assign lane_issue = {grant.mult_issue, grant.alu_issue};
    assign lane_index = {grant.mult_index, grant.alu_index};

    for (genvar p = 0; p < issue_pkg::num_read_ports; p++) begin : g_port
        issue_pkg::phys_reg_idx_t src_tag;
        // even port reads source 1, odd port source 2
        assign src_tag = (p % 2 == 0) ? rs_src1[lane_index[p/2]] : rs_src2[lane_index[p/2]];
        // idle ports read register 0
        assign rf_read_idx[p] = lane_issue[p/2] ? src_tag : '0;
        assign operand[p] = lane_issue[p/2] ?
            forward_operand(src_tag, rf_read_data[p], complete_list, cdb_valid, cdb_tag,
                            cdb_result) : '0;
    end

    always_comb begin
        rs_issuing = '0;
        for (int l = 0; l < issue_pkg::num_read_ports / 2; l++) begin
            if (lane_issue[l]) begin
                rs_issuing[lane_index[l]] = 1'b1;
            end
        end

        // alu packets, alu_op view of the function code
        for (int k = 0; k < issue_pkg::num_alu; k++) begin
            alu_valid[k] = lane_issue[k];
            alu_dest[k] = '0;
            alu_op[k] = issue_pkg::alu_add;
            alu_opa[k] = operand[2*k];
            alu_opb[k] = operand[2*k+1];
            if (lane_issue[k]) begin
                alu_dest[k] = rs_dest[lane_index[k]];
                alu_op[k] = rs_func[lane_index[k]].alu_op;
            end
        end

        // mult packet, mult view of the same word
        mult_valid = lane_issue[issue_pkg::num_alu];
        mult_dest = '0;
        mult_kind = issue_pkg::mult_low;
        mult_opa = operand[2*issue_pkg::num_alu];
        mult_opb = operand[2*issue_pkg::num_alu+1];
        if (mult_valid) begin
            mult_dest = rs_dest[grant.mult_index];
            mult_kind = rs_func[grant.mult_index].mult.mult_kind;
        end
    end

endmodule

//--- hdl/priority_select.sv
module priority_select #(
    parameter int width = 8,
    parameter int grants = 2
) (
    input  logic [width-1:0]              req,
    output logic [grants-1:0][width-1:0]  gnt,
    output logic [grants-1:0]             any
);

    // requests not yet taken by an earlier grant
    logic [width-1:0] remaining;

    always_comb begin
        remaining = req;
        for (int k = 0; k < grants; k++) begin
            // isolate lowest set bit
            gnt[k] = remaining & (~remaining + width'(1));
            any[k] = |remaining;
            // drop it so grant k+1 sees the next one up
            remaining = remaining & ~gnt[k];
        end
    end

endmodule

//--- sim.f
hdl/issue_pkg.sv
hdl/issue_grant_if.sv
hdl/priority_select.sv
hdl/entry_select.sv
hdl/cdb_arbiter.sv
hdl/operand_gather.sv
hdl/issue_stage.sv
test/issue_stage_asserts.sv
test/tb_issue_stage.sv

//--- test/issue_stage_asserts.sv
module issue_stage_asserts (
    input logic                                                         clock,
    input logic                                                         reset,
    input logic [issue_pkg::rs_size-1:0]                                rs_valid,
    input logic [issue_pkg::rs_size-1:0]                                rs_src1_ready,
    input logic [issue_pkg::rs_size-1:0]                                rs_src2_ready,
    input logic [issue_pkg::rs_size-1:0]                                rs_issuing,
    input logic                                                         mult_cdb_req,
    input logic                                                         mult_cdb_gnt,
    input logic [issue_pkg::cdb_width-1:0][issue_pkg::num_fu_total-1:0] complete_gnt
);

    timeunit 1ns;
    timeprecision 100ps;

    // an issuing entry must be valid with both sources ready
    issuing_only_ready: assert property (@(posedge clock) disable iff (reset)
        (rs_issuing & ~(rs_valid & rs_src1_ready & rs_src2_ready)) == '0)
        else $error("rs_issuing marks an entry that is not valid and ready");

    // cdb slot for the multiplier only on request
    mult_gnt_needs_req: assert property (@(posedge clock) disable iff (reset)
        mult_cdb_gnt |-> mult_cdb_req)
        else $error("mult_cdb_gnt without mult_cdb_req");

    // never more owners than cdb slots
    slot_count_bound: assert property (@(posedge clock) disable iff (reset)
        $countones(complete_gnt) <= issue_pkg::cdb_width)
        else $error("complete_gnt grants more units than cdb slots");

endmodule

//--- test/tb_issue_stage.sv
module tb_issue_stage;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clock_period = 100;
    localparam int reset_cycles = 4;
    localparam int num_cycles = 2000;

    logic clock;
    logic reset;
    logic [issue_pkg::rs_size-1:0] rs_valid;
    logic [issue_pkg::rs_size-1:0] rs_src1_ready;
    logic [issue_pkg::rs_size-1:0] rs_src2_ready;
    logic [issue_pkg::rs_size-1:0] rs_fu_class;
    issue_pkg::phys_reg_idx_t [issue_pkg::rs_size-1:0] rs_src1;
    issue_pkg::phys_reg_idx_t [issue_pkg::rs_size-1:0] rs_src2;
    issue_pkg::phys_reg_idx_t [issue_pkg::rs_size-1:0] rs_dest;
    logic [issue_pkg::rs_size-1:0][3:0] rs_func;
    logic [issue_pkg::rs_size-1:0] rs_issuing;
    logic [issue_pkg::phys_reg_count-1:0] complete_list;
    logic [issue_pkg::cdb_width-1:0] cdb_valid;
    issue_pkg::phys_reg_idx_t [issue_pkg::cdb_width-1:0] cdb_tag;
    issue_pkg::data_t [issue_pkg::cdb_width-1:0] cdb_result;
    issue_pkg::phys_reg_idx_t [issue_pkg::num_read_ports-1:0] rf_read_idx;
    issue_pkg::data_t [issue_pkg::num_read_ports-1:0] rf_read_data;
    logic mult_free;
    logic mult_cdb_req;
    logic mult_cdb_gnt;
    logic [issue_pkg::cdb_width-1:0][issue_pkg::num_fu_total-1:0] complete_gnt;
    logic [issue_pkg::num_alu-1:0] alu_valid;
    issue_pkg::phys_reg_idx_t [issue_pkg::num_alu-1:0] alu_dest;
    logic [issue_pkg::num_alu-1:0][3:0] alu_op;
    issue_pkg::data_t [issue_pkg::num_alu-1:0] alu_opa;
    issue_pkg::data_t [issue_pkg::num_alu-1:0] alu_opb;
    logic mult_valid;
    issue_pkg::phys_reg_idx_t mult_dest;
    logic [1:0] mult_kind;
    issue_pkg::data_t mult_opa;
    issue_pkg::data_t mult_opb;

    // register file contents stay fixed after start
    issue_pkg::data_t rf_mem [issue_pkg::phys_reg_count];

    // expected values of the current cycle
    logic [issue_pkg::rs_size-1:0] exp_rs_issuing;
    issue_pkg::phys_reg_idx_t [issue_pkg::num_read_ports-1:0] exp_rf_read_idx;
    logic [issue_pkg::num_alu-1:0] exp_alu_valid;
    issue_pkg::phys_reg_idx_t [issue_pkg::num_alu-1:0] exp_alu_dest;
    logic [issue_pkg::num_alu-1:0][3:0] exp_alu_op;
    issue_pkg::data_t [issue_pkg::num_alu-1:0] exp_alu_opa;
    issue_pkg::data_t [issue_pkg::num_alu-1:0] exp_alu_opb;
    logic exp_mult_valid;
    issue_pkg::phys_reg_idx_t exp_mult_dest;
    logic [1:0] exp_mult_kind;
    issue_pkg::data_t exp_mult_opa;
    issue_pkg::data_t exp_mult_opb;
    logic exp_mult_cdb_gnt;
    logic [issue_pkg::cdb_width-1:0][issue_pkg::num_fu_total-1:0] exp_slot_gnt;
    // slot owners of the last cycle as complete_gnt shows them after the edge
    logic [issue_pkg::cdb_width-1:0][issue_pkg::num_fu_total-1:0] prev_slot_gnt = '0;

    int seed = 32'h52e5_a34f;
    int error_count = 0;
    logic checking = 1'b0;

    issue_stage i_issue_stage (
        .clock         (clock),
        .reset         (reset),
        .rs_valid      (rs_valid),
        .rs_src1_ready (rs_src1_ready),
        .rs_src2_ready (rs_src2_ready),
        .rs_fu_class   (rs_fu_class),
        .rs_src1       (rs_src1),
        .rs_src2       (rs_src2),
        .rs_dest       (rs_dest),
        .rs_func       (rs_func),
        .rs_issuing    (rs_issuing),
        .complete_list (complete_list),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .cdb_result    (cdb_result),
        .rf_read_idx   (rf_read_idx),
        .rf_read_data  (rf_read_data),
        .mult_free     (mult_free),
        .mult_cdb_req  (mult_cdb_req),
        .mult_cdb_gnt  (mult_cdb_gnt),
        .complete_gnt  (complete_gnt),
        .alu_valid     (alu_valid),
        .alu_dest      (alu_dest),
        .alu_op        (alu_op),
        .alu_opa       (alu_opa),
        .alu_opb       (alu_opb),
        .mult_valid    (mult_valid),
        .mult_dest     (mult_dest),
        .mult_kind     (mult_kind),
        .mult_opa      (mult_opa),
        .mult_opb      (mult_opb)
    );

    bind issue_stage issue_stage_asserts i_issue_stage_asserts (
        .clock         (clock),
        .reset         (reset),
        .rs_valid      (rs_valid),
        .rs_src1_ready (rs_src1_ready),
        .rs_src2_ready (rs_src2_ready),
        .rs_issuing    (rs_issuing),
        .mult_cdb_req  (mult_cdb_req),
        .mult_cdb_gnt  (mult_cdb_gnt),
        .complete_gnt  (complete_gnt)
    );

    // register file model answers the read ports at once
    always_comb begin
        for (int p = 0; p < issue_pkg::num_read_ports; p++) begin
            rf_read_data[p] = rf_mem[rf_read_idx[p]];
        end
    end

    initial begin : clock_gen
        clock = 1'b0;
        forever begin
            #(clock_period / 2);
            clock = ~clock;
        end
    end

    task automatic check_value(
        input string name,
        input logic [63:0] actual,
        input logic [63:0] expected
    );
        if (actual !== expected) begin
            error_count++;
            $display("error at %0d ns: %s expected %0h, got %0h", $time, name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // committed register first, then the newest matching cdb slot, else zero
    function automatic issue_pkg::data_t expected_operand(input issue_pkg::phys_reg_idx_t tag);
        issue_pkg::data_t value;
        logic found;
        value = '0;
        found = 1'b0;
        if (complete_list[tag]) begin
            value = rf_mem[tag];
        end else begin
            for (int s = issue_pkg::cdb_width - 1; s >= 0; s--) begin
                if (!found && cdb_valid[s] && cdb_tag[s] == tag) begin
                    value = cdb_result[s];
                    found = 1'b1;
                end
            end
        end
        return value;
    endfunction

    // reference model with alu lanes 0 and 1 and the multiplier as lane 2
    function automatic void predict_outputs();
        logic [2:0] lane_go;
        issue_pkg::rs_index_t [2:0] lane_entry;
        logic [issue_pkg::num_fu_total-1:0] unit_req;
        logic [issue_pkg::num_fu_total-1:0] unit_won;
        issue_pkg::data_t [issue_pkg::num_read_ports-1:0] opnd;
        int alu_found;
        int slot;
        logic mult_found;
        lane_go = '0;
        lane_entry = '0;
        alu_found = 0;
        mult_found = 1'b0;
        for (int i = 0; i < issue_pkg::rs_size; i++) begin
            if (rs_valid[i] && rs_src1_ready[i] && rs_src2_ready[i]) begin
                if (rs_fu_class[i] == issue_pkg::fu_alu && alu_found < issue_pkg::num_alu) begin
                    lane_go[alu_found] = 1'b1;
                    lane_entry[alu_found] = issue_pkg::rs_index_t'(i);
                    alu_found++;
                end else if (rs_fu_class[i] == issue_pkg::fu_mult && !mult_found) begin
                    mult_found = 1'b1;
                    lane_entry[2] = issue_pkg::rs_index_t'(i);
                end
            end
        end
        // cdb slots go to the mult result, then lane 0, then lane 1
        unit_req = {lane_go[1], lane_go[0], mult_cdb_req};
        unit_won = '0;
        exp_slot_gnt = '0;
        slot = 0;
        for (int u = 0; u < issue_pkg::num_fu_total; u++) begin
            if (unit_req[u] && slot < issue_pkg::cdb_width) begin
                exp_slot_gnt[slot][u] = 1'b1;
                unit_won[u] = 1'b1;
                slot++;
            end
        end
        exp_mult_cdb_gnt = unit_won[0];
        lane_go[0] = lane_go[0] & unit_won[1];
        lane_go[1] = lane_go[1] & unit_won[2];
        lane_go[2] = mult_found & mult_free;
        exp_rs_issuing = '0;
        for (int l = 0; l < 3; l++) begin
            exp_rf_read_idx[2*l] = lane_go[l] ? rs_src1[lane_entry[l]] : '0;
            exp_rf_read_idx[2*l+1] = lane_go[l] ? rs_src2[lane_entry[l]] : '0;
            opnd[2*l] = lane_go[l] ? expected_operand(rs_src1[lane_entry[l]]) : '0;
            opnd[2*l+1] = lane_go[l] ? expected_operand(rs_src2[lane_entry[l]]) : '0;
            if (lane_go[l]) begin
                exp_rs_issuing[lane_entry[l]] = 1'b1;
            end
        end
        for (int k = 0; k < issue_pkg::num_alu; k++) begin
            exp_alu_valid[k] = lane_go[k];
            exp_alu_dest[k] = lane_go[k] ? rs_dest[lane_entry[k]] : '0;
            exp_alu_op[k] = lane_go[k] ? rs_func[lane_entry[k]] : '0;
            exp_alu_opa[k] = opnd[2*k];
            exp_alu_opb[k] = opnd[2*k+1];
        end
        exp_mult_valid = lane_go[2];
        exp_mult_dest = lane_go[2] ? rs_dest[lane_entry[2]] : '0;
        // mult kind lives in the low two bits of the function code
        exp_mult_kind = lane_go[2] ? rs_func[lane_entry[2]][1:0] : '0;
        exp_mult_opa = opnd[4];
        exp_mult_opb = opnd[5];
    endfunction

    task automatic drive_random();
        logic [31:0] r1;
        logic [31:0] r2;
        r1 = $random(seed);
        r2 = $random(seed);
        // bias valid and ready bits high so more entries compete
        rs_valid = r1[7:0] | r2[7:0];
        rs_src1_ready = r1[15:8] | r2[15:8];
        rs_src2_ready = r1[23:16] | r2[23:16];
        rs_fu_class = r1[31:24];
        for (int i = 0; i < issue_pkg::rs_size; i++) begin
            r1 = $random(seed);
            rs_src1[i] = r1[4:0];
            rs_src2[i] = r1[9:5];
            rs_dest[i] = r1[14:10];
            rs_func[i] = r1[18:15];
        end
        r1 = $random(seed);
        r2 = $random(seed);
        complete_list = r1 & r2;
        for (int s = 0; s < issue_pkg::cdb_width; s++) begin
            r1 = $random(seed);
            cdb_valid[s] = r1[0];
            // often hit an rs source tag so forwarding is exercised
            cdb_tag[s] = r1[1] ? rs_src1[r1[4:2]] : r1[9:5];
            if (s > 0 && r1[10]) begin
                cdb_tag[s] = cdb_tag[0];
            end
            cdb_result[s] = $random(seed);
        end
        r1 = $random(seed);
        mult_free = r1[0];
        mult_cdb_req = r1[1];
    endtask

    initial begin : compare_outputs
        forever begin
            @(negedge clock);
            #(clock_period * 2 / 5);
            if (checking) begin
                check_value("complete_gnt", 64'(complete_gnt), 64'(prev_slot_gnt));
                predict_outputs();
                check_value("mult_cdb_gnt", 64'(mult_cdb_gnt), 64'(exp_mult_cdb_gnt));
                check_value("rs_issuing", 64'(rs_issuing), 64'(exp_rs_issuing));
                check_value("rf_read_idx", 64'(rf_read_idx), 64'(exp_rf_read_idx));
                check_value("alu_valid", 64'(alu_valid), 64'(exp_alu_valid));
                check_value("alu_dest", 64'(alu_dest), 64'(exp_alu_dest));
                check_value("alu_op", 64'(alu_op), 64'(exp_alu_op));
                check_value("alu_opa", 64'(alu_opa), 64'(exp_alu_opa));
                check_value("alu_opb", 64'(alu_opb), 64'(exp_alu_opb));
                check_value("mult_valid", 64'(mult_valid), 64'(exp_mult_valid));
                check_value("mult_dest", 64'(mult_dest), 64'(exp_mult_dest));
                check_value("mult_kind", 64'(mult_kind), 64'(exp_mult_kind));
                check_value("mult_opa", 64'(mult_opa), 64'(exp_mult_opa));
                check_value("mult_opb", 64'(mult_opb), 64'(exp_mult_opb));
                prev_slot_gnt = exp_slot_gnt;
            end
        end
    end

    initial begin : stimulus
        reset = 1'b1;
        rs_valid = '0;
        rs_src1_ready = '0;
        rs_src2_ready = '0;
        rs_fu_class = '0;
        rs_src1 = '0;
        rs_src2 = '0;
        rs_dest = '0;
        rs_func = '0;
        complete_list = '0;
        cdb_valid = '0;
        cdb_tag = '0;
        cdb_result = '0;
        mult_free = 1'b0;
        mult_cdb_req = 1'b0;
        for (int r = 0; r < issue_pkg::phys_reg_count; r++) begin
            rf_mem[r] = $random(seed);
        end
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        checking = 1'b1;
        for (int c = 0; c < num_cycles; c++) begin
            drive_random();
            @(negedge clock);
        end
        checking = 1'b0;
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #(clock_period * (num_cycles + 100));
        $display("watchdog: run did not finish within %0d clock periods", num_cycles + 100);
        $display("TEST FAIL");
        $fatal(1, "timeout");
    end

endmodule
